// File: design/noc_defines.svh
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// Number of PE tiles on the row
`define PE_COUNT 4

// Stream widths
`define DATA_W 128
`define DEST_W 4
`define ID_W 2

// Lane split of a beat for the tile sums
`define LANE_W 32
`define LANES 4

// Tile input queue depth
`define FIFO_DEPTH 4

`endif

// File: design/noc_pkg.sv
`include "noc_defines.svh"

package noc_pkg;

    // One beat on the input stream
    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic [`DEST_W-1:0] dest;
        logic [`ID_W-1:0]   id;
        logic               last;
    } flit_t;

    // Four lane sums of one packet, tagged with its source tile
    typedef struct packed {
        logic [`DATA_W-1:0] sum;
        logic [`DEST_W-1:0] src;
        logic [`ID_W-1:0]   id;
    } result_t;

endpackage

// File: design/axis_if.sv
`timescale 1ns/1ps

`include "noc_defines.svh"

interface axis_if;

    logic               tvalid;
    logic               tready;
    logic [`DATA_W-1:0] tdata;
    logic [`DEST_W-1:0] tdest;
    logic [`ID_W-1:0]   tid;
    logic               tlast;

    // Sender side
    modport src (
        output tvalid, tdata, tdest, tid, tlast,
        input  tready
    );

    // Receiver side
    modport dst (
        input  tvalid, tdata, tdest, tid, tlast,
        output tready
    );

endinterface

// File: design/stream_fifo.sv
`timescale 1ns/1ps

`include "noc_defines.svh"

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_valid,
    output logic     wr_ready,
    input  payload_t wr_data,
    output logic     rd_valid,
    input  logic     rd_ready,
    output payload_t rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign wr_ready = (count != CNT_FULL);
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign do_wr = wr_valid && wr_ready;
    assign do_rd = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves occupancy alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: design/noc_ingress_router.sv
`timescale 1ns/1ps

`include "noc_defines.svh"

module noc_ingress_router (
    input  logic           in_valid,
    output logic           in_ready,
    input  noc_pkg::flit_t in_flit,
    axis_if.src            tiles [`PE_COUNT]
);

    logic [`PE_COUNT-1:0] sel;
    logic [`PE_COUNT-1:0] tile_ready;
    logic                 dest_ok;

    for (genvar i = 0; i < `PE_COUNT; i++) begin : g_port
        // One-hot decode of the dest field
        assign sel[i] = (int'(in_flit.dest) == i);

        assign tiles[i].tvalid = in_valid && sel[i];
        assign tiles[i].tdata  = in_flit.data;
        assign tiles[i].tdest  = in_flit.dest;
        assign tiles[i].tid    = in_flit.id;
        assign tiles[i].tlast  = in_flit.last;

        assign tile_ready[i] = tiles[i].tready;
    end

    assign dest_ok = |sel;

    // Beats for a dest with no tile are swallowed
    assign in_ready = !dest_ok || |(sel & tile_ready);

endmodule

// File: design/pe_tile.sv
`timescale 1ns/1ps

`include "noc_defines.svh"

module pe_tile #(
    parameter int TILE_ID = 0
) (
    input  logic             clk,
    input  logic             rst,
    axis_if.dst              in_port,
    output logic             res_valid,
    input  logic             res_ready,
    output noc_pkg::result_t res
);

    noc_pkg::flit_t     wr_flit;
    noc_pkg::flit_t     q_flit;
    logic               q_valid;
    logic               q_ready;
    logic               pop;
    logic               res_free;
    logic [`DATA_W-1:0] acc;
    logic [`DATA_W-1:0] lane_sum;

    assign wr_flit.data = in_port.tdata;
    assign wr_flit.dest = in_port.tdest;
    assign wr_flit.id   = in_port.tid;
    assign wr_flit.last = in_port.tlast;

    // Input queue
    stream_fifo #(
        .payload_t (noc_pkg::flit_t),
        .DEPTH     (`FIFO_DEPTH)
    ) u_queue (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (in_port.tvalid),
        .wr_ready (in_port.tready),
        .wr_data  (wr_flit),
        .rd_valid (q_valid),
        .rd_ready (q_ready),
        .rd_data  (q_flit)
    );

    // Result slot frees up when empty or being drained this cycle
    assign res_free = !res_valid || res_ready;

    // Only a last beat has to wait for the result slot
    assign q_ready = !q_flit.last || res_free;
    assign pop     = q_valid && q_ready;

    always_comb begin
        for (int l = 0; l < `LANES; l++) begin
            lane_sum[l*`LANE_W +: `LANE_W] = acc[l*`LANE_W +: `LANE_W]
                                           + q_flit.data[l*`LANE_W +: `LANE_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc       <= '0;
            res_valid <= 1'b0;
        end else if (pop && q_flit.last) begin
            acc       <= '0;
            res_valid <= 1'b1;
        end else begin
            if (pop) begin
                acc <= lane_sum;
            end
            if (res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (pop && q_flit.last) begin
            res.sum <= lane_sum;
            res.src <= TILE_ID[`DEST_W-1:0];
            res.id  <= q_flit.id;
        end
    end

endmodule

// File: design/noc_egress_arbiter.sv
`timescale 1ns/1ps

`include "noc_defines.svh"

module noc_egress_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`PE_COUNT-1:0] res_valid,
    output logic [`PE_COUNT-1:0] res_ready,
    input  noc_pkg::result_t     res [`PE_COUNT],
    output logic                 out_valid,
    input  logic                 out_ready,
    output noc_pkg::result_t     out_res
);

    localparam int IDX_W = $clog2(`PE_COUNT);
    localparam logic [IDX_W-1:0] LAST_INIT = IDX_W'(`PE_COUNT - 1);

    logic [IDX_W-1:0]     last_idx;
    logic [IDX_W-1:0]     grant_idx;
    logic                 found;
    logic [`PE_COUNT-1:0] grant;
    logic                 stage_valid;
    logic                 stage_ready;

    // Round-robin search starting after the previous winner
    always_comb begin
        int idx;
        found     = 1'b0;
        grant_idx = last_idx;
        grant     = '0;
        for (int k = 1; k <= `PE_COUNT; k++) begin
            idx = (int'(last_idx) + k) % `PE_COUNT;
            if (!found && res_valid[idx]) begin
                found      = 1'b1;
                grant_idx  = idx[IDX_W-1:0];
                grant[idx] = 1'b1;
            end
        end
    end

    assign stage_valid = found;
    assign res_ready   = grant & {`PE_COUNT{stage_ready}};

    always_ff @(posedge clk) begin
        if (rst) begin
            last_idx <= LAST_INIT;
        end else if (stage_valid && stage_ready) begin
            last_idx <= grant_idx;
        end
    end

    // Output register, two deep so it refills while draining
    stream_fifo #(
        .payload_t (noc_pkg::result_t),
        .DEPTH     (2)
    ) u_out_stage (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (stage_valid),
        .wr_ready (stage_ready),
        .wr_data  (res[grant_idx]),
        .rd_valid (out_valid),
        .rd_ready (out_ready),
        .rd_data  (out_res)
    );

endmodule

// File: design/pe_noc.sv
`timescale 1ns/1ps

`include "noc_defines.svh"

module pe_noc (
    input  logic               clk,
    input  logic               rst,

    // Input stream
    input  logic [`DATA_W-1:0] in_data,
    input  logic               in_valid,
    output logic               in_ready,
    input  logic [`DEST_W-1:0] in_dest,
    input  logic [`ID_W-1:0]   in_id,
    input  logic               in_last,

    // Output stream, dest carries the source tile
    output logic [`DATA_W-1:0] out_data,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [`DEST_W-1:0] out_dest,
    output logic [`ID_W-1:0]   out_id
);

    noc_pkg::flit_t       in_flit;
    noc_pkg::result_t     tile_res [`PE_COUNT];
    noc_pkg::result_t     out_res;
    logic [`PE_COUNT-1:0] res_valid;
    logic [`PE_COUNT-1:0] res_ready;

    axis_if tile_links [`PE_COUNT] ();

    assign in_flit.data = in_data;
    assign in_flit.dest = in_dest;
    assign in_flit.id   = in_id;
    assign in_flit.last = in_last;

    noc_ingress_router u_router (
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_flit  (in_flit),
        .tiles    (tile_links)
    );

    for (genvar i = 0; i < `PE_COUNT; i++) begin : g_tile
        pe_tile #(
            .TILE_ID (i)
        ) u_tile (
            .clk       (clk),
            .rst       (rst),
            .in_port   (tile_links[i]),
            .res_valid (res_valid[i]),
            .res_ready (res_ready[i]),
            .res       (tile_res[i])
        );
    end

    noc_egress_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (tile_res),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

    assign out_data = out_res.sum;
    assign out_dest = out_res.src;
    assign out_id   = out_res.id;

endmodule

// File: tests/pe_noc_tb.sv
`timescale 1ns/1ps

`include "noc_defines.svh"

module pe_noc_tb;

    logic               clk;
    logic               rst;
    logic [`DATA_W-1:0] in_data;
    logic               in_valid;
    logic               in_ready;
    logic [`DEST_W-1:0] in_dest;
    logic [`ID_W-1:0]   in_id;
    logic               in_last;
    logic [`DATA_W-1:0] out_data;
    logic               out_valid;
    logic               out_ready;
    logic [`DEST_W-1:0] out_dest;
    logic [`ID_W-1:0]   out_id;

    // Expected {sum, id} per tile, oldest first
    logic [`DATA_W+`ID_W-1:0] exp_q [`PE_COUNT][$];
    // Source tiles in output order
    int          out_log [$];
    int          errors;
    int          beats_sent;
    int          cycles;
    logic [31:0] lfsr;
    string       test_name;

    pe_noc DUT (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_dest   (in_dest),
        .in_id     (in_id),
        .in_last   (in_last),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dest  (out_dest),
        .out_id    (out_id)
    );

    always #5 clk = ~clk;

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int t = 0; t < `PE_COUNT; t++) begin
            n += exp_q[t].size();
        end
        return n;
    endfunction

    task automatic check_value(string what, logic [`DATA_W-1:0] expected,
                               logic [`DATA_W-1:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", what, expected, actual);
            errors++;
        end
    endtask

    // Output monitor, matched against the queue of the source tile
    always @(posedge clk) begin
        int                       src;
        logic [`DATA_W+`ID_W-1:0] head;
        src = int'(out_dest);
        if (!rst && out_valid && out_ready) begin
            out_log.push_back(src);
            if (src >= `PE_COUNT || exp_q[src].size() == 0) begin
                $display("%s: output from tile %0d with no result expected", test_name, src);
                errors++;
            end else begin
                head = exp_q[src].pop_front();
                check_value(test_name, head[`DATA_W+`ID_W-1:`ID_W], out_data);
                check_value(test_name, `DATA_W'(head[`ID_W-1:0]), `DATA_W'(out_id));
            end
        end
    end

    // Run limit grows with the traffic sent
    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * beats_sent + 2000) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic send_beat(logic [`DEST_W-1:0] dest, logic [`ID_W-1:0] id,
                             logic [`DATA_W-1:0] data, logic last);
        @(negedge clk);
        in_valid = 1'b1;
        in_dest  = dest;
        in_id    = id;
        in_data  = data;
        in_last  = last;
        #1;
        while (!in_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        beats_sent++;
    endtask

    task automatic send_packet(logic [`DEST_W-1:0] dest, logic [`ID_W-1:0] id, int beats);
        logic [`DATA_W-1:0] data;
        logic [`DATA_W-1:0] sum;
        sum = '0;
        for (int b = 0; b < beats; b++) begin
            for (int l = 0; l < `LANES; l++) begin
                data[l*`LANE_W +: `LANE_W] = rand_bits(32);
                // Lanes wrap modulo 2^32
                sum[l*`LANE_W +: `LANE_W] = sum[l*`LANE_W +: `LANE_W]
                                          + data[l*`LANE_W +: `LANE_W];
            end
            send_beat(dest, id, data, b == beats - 1);
        end
        if (int'(dest) < `PE_COUNT) begin
            exp_q[int'(dest)].push_back({sum, id});
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Wait until every expected result came out, then a few spare cycles
    task automatic drain(bit random_ready);
        logic [31:0] r;
        int          waited;
        waited = 0;
        while (pending() != 0 && waited < 1000) begin
            @(negedge clk);
            r = random_ready ? rand_bits(1) : 32'd1;
            out_ready = r[0];
            waited++;
        end
        repeat (5) @(negedge clk);
        out_ready = 1'b1;
    endtask

    task automatic reset_state();
        test_name = "reset";
        check_value(test_name, `DATA_W'(0), `DATA_W'(out_valid));
        check_value(test_name, `DATA_W'(1), `DATA_W'(in_ready));
    endtask

    task automatic single_beat_packets();
        test_name = "single_beat";
        for (int t = 0; t < `PE_COUNT; t++) begin
            send_packet(`DEST_W'(t), `ID_W'(t), 1);
        end
        drain(1'b0);
    endtask

    task automatic interleaved_packets();
        logic [31:0] d;
        logic [31:0] len;
        logic [31:0] id;
        test_name = "multi_beat";
        for (int p = 0; p < 16; p++) begin
            d   = rand_bits(2);
            len = rand_bits(3);
            id  = rand_bits(2);
            send_packet(`DEST_W'(d), `ID_W'(id), 1 + int'(len));
        end
        drain(1'b0);
    endtask

    task automatic output_backpressure();
        bit stalled;
        stalled   = 1'b0;
        test_name = "backpressure";
        @(negedge clk);
        out_ready = 1'b0;
        fork
            for (int p = 0; p < 10; p++) begin
                send_packet(`DEST_W'(1), `ID_W'(p), 2);
            end
            begin
                for (int c = 0; c < 400 && !stalled; c++) begin
                    @(negedge clk);
                    #2;
                    if (in_valid && !in_ready) begin
                        stalled = 1'b1;
                    end
                end
                @(negedge clk);
                out_ready = 1'b1;
            end
        join
        if (!stalled) begin
            $display("%s: in_ready never fell while the output was held", test_name);
            errors++;
        end
        drain(1'b0);
    endtask

    task automatic invalid_dests();
        test_name = "invalid_dest";
        send_packet(`DEST_W'(4), `ID_W'(1), 3);
        send_packet(`DEST_W'(9), `ID_W'(2), 1);
        send_packet(`DEST_W'(15), `ID_W'(3), 2);
        send_packet(`DEST_W'(2), `ID_W'(0), 2);
        drain(1'b0);
        // Dropped beats leave nothing behind in the output stage
        check_value(test_name, `DATA_W'(0), `DATA_W'(out_valid));
    endtask

    task automatic arbiter_fairness();
        logic [`PE_COUNT-1:0] seen [3];
        test_name = "fairness";
        @(negedge clk);
        out_ready = 1'b0;
        out_log.delete();
        for (int p = 0; p < 3; p++) begin
            for (int t = 0; t < `PE_COUNT; t++) begin
                send_packet(`DEST_W'(t), `ID_W'(p), 1);
            end
        end
        drain(1'b1);
        // Every tile holds results, so each round serves all of them once
        seen = '{default: '0};
        for (int i = 0; i < out_log.size() && i < 3 * `PE_COUNT; i++) begin
            seen[i / `PE_COUNT][out_log[i]] = 1'b1;
        end
        for (int g = 0; g < 3; g++) begin
            check_value(test_name, `DATA_W'({`PE_COUNT{1'b1}}), `DATA_W'(seen[g]));
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        in_data    = '0;
        in_valid   = 1'b0;
        in_dest    = '0;
        in_id      = '0;
        in_last    = 1'b0;
        out_ready  = 1'b1;
        errors     = 0;
        beats_sent = 0;
        lfsr       = 32'd92759;
        test_name  = "idle";
        repeat (10) @(negedge clk);
        rst = 1'b0;

        reset_state();
        single_beat_packets();
        interleaved_packets();
        output_backpressure();
        invalid_dests();
        arbiter_fairness();

        for (int t = 0; t < `PE_COUNT; t++) begin
            if (exp_q[t].size() != 0) begin
                $display("tile %0d never delivered %0d expected results", t, exp_q[t].size());
                errors++;
            end
        end
        $display("summary: %0d errors over %0d beats sent", errors, beats_sent);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: pe_noc.f
+incdir+design
design/noc_pkg.sv
design/axis_if.sv
design/stream_fifo.sv
design/noc_ingress_router.sv
design/pe_tile.sv
design/noc_egress_arbiter.sv
design/pe_noc.sv
tests/pe_noc_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = pe_noc_tb
RTL_TOP  = pe_noc
FILELIST = pe_noc.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
